// File: cache.f
+incdir+.
source/cache_pkg.sv
source/cache_decode.sv
source/cache_ctrl.sv
source/cache_execute.sv
source/cache_result.sv
source/cache_top.sv
dv/mem_model.sv
dv/cache_tb.sv

// File: cache_cfg.svh
`ifndef CACHE_CFG_SVH
`define CACHE_CFG_SVH

// address split of a 32-bit byte address
`define CACHE_TAG_BITS   21
`define CACHE_INDEX_BITS 5
`define CACHE_WOFS_BITS  4
`define CACHE_BOFS_BITS  2  // byte offset, ignored on access

// geometry
`define CACHE_LINES      32
`define CACHE_LINE_WORDS 16

`endif

// File: dv/cache_tb.sv
`include "cache_cfg.svh"

module cache_tb;
  import cache_pkg::*;

  localparam int RAND_SEED    = 32'h96ad_1eb5;
  localparam int RESET_CYCLES = 16;
  localparam int IDLE_CYCLES  = 8;
  localparam int RANDOM_OPS   = 200;
  localparam int OPS          = RANDOM_OPS + 6;
  // worst case per access is a dirty miss at the longest memory delay
  localparam int MAX_CYCLES   = OPS * (32 * 5 + 4) + RESET_CYCLES + IDLE_CYCLES;

  logic        clk = 1'b0;
  logic        reset;
  logic        req_valid;
  cache_req_t  req;
  logic        busy;
  logic        resp_valid;
  cache_resp_t resp;
  logic        mem_req_valid;
  mem_req_t    mem_req;
  logic        mem_resp_valid;
  mem_resp_t   mem_resp;

  integer      seed;
  logic [31:0] shadow [4096];
  logic [7:0]  exp_opaque;
  int          cycle_count = 0;
  int          mem_reads;
  int          mem_writes;
  logic [15:0] read_mask;
  logic [15:0] write_mask;
  logic [25:0] watch_line;  // line address of the current request
  logic        mem_pending;
  string       cur_test = "reset_state";
  int          lat;
  logic [31:0] rnd;
  logic [31:0] addr_a;
  logic [31:0] addr_b;

  always #10 clk = ~clk;

  cache_top u_cache_top (
    .clk            (clk),
    .reset          (reset),
    .req_valid      (req_valid),
    .req            (req),
    .busy           (busy),
    .resp_valid     (resp_valid),
    .resp           (resp),
    .mem_req_valid  (mem_req_valid),
    .mem_req        (mem_req),
    .mem_resp_valid (mem_resp_valid),
    .mem_resp       (mem_resp)
  );

  mem_model #(.SEED(RAND_SEED)) u_mem_model (
    .clk        (clk),
    .reset      (reset),
    .req_valid  (mem_req_valid),
    .req        (mem_req),
    .resp_valid (mem_resp_valid),
    .resp       (mem_resp)
  );

  function automatic logic [31:0] pattern_word(input logic [11:0] a);
    return {a, 4'h5, a, 4'ha} ^ 32'h3c00_00c3;
  endfunction

  function automatic logic [31:0] make_addr(
    input logic [`CACHE_TAG_BITS-1:0]   tag,
    input logic [`CACHE_INDEX_BITS-1:0] index,
    input logic [`CACHE_WOFS_BITS-1:0]  wofs,
    input logic [1:0]                   bofs
  );
    return {tag, index, wofs, bofs};
  endfunction

  task automatic stop_on_failure(input string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_equal(input string test, input string what,
                             input logic [31:0] expected, input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("ERROR %s: %s expected %h actual %h", test, what, expected, actual);
      $display("Simulation failed");
      $fatal(1);
    end
  endtask

  // one client access and its latency from req_valid to resp_valid
  task automatic access(input string test, input req_type_e kind, input logic [31:0] addr,
                        input logic [31:0] wdata, output int latency);
    cache_req_t r;
    @(negedge clk);
    while (busy) @(negedge clk);
    @(posedge clk);
    cur_test   = test;
    exp_opaque = exp_opaque + 8'd1;
    mem_reads  = 0;
    mem_writes = 0;
    read_mask  = '0;
    write_mask = '0;
    watch_line = addr[31:6];
    r.type_    = kind;
    r.opaque   = exp_opaque;
    r.addr.raw = addr;
    r.data     = wdata;
    req_valid <= 1'b1;
    req       <= r;
    @(posedge clk);
    req_valid <= 1'b0;
    latency = 1;
    @(negedge clk);
    while (!resp_valid) begin
      check_equal(test, "busy", 32'd1, 32'(busy));
      latency++;
      @(negedge clk);
    end
    check_equal(test, "busy", 32'd1, 32'(busy));
    check_equal(test, "response type", 32'(kind), 32'(resp.type_));
    check_equal(test, "opaque", 32'(exp_opaque), 32'(resp.opaque));
    if (kind == REQ_WRITE) begin
      shadow[addr[13:2]] = wdata;
    end else begin
      check_equal(test, "read data", shadow[addr[13:2]], resp.data);
    end
  endtask

  // memory port monitor
  always @(negedge clk) begin
    if (!reset) begin
      if (mem_resp_valid) begin
        mem_pending = 1'b0;
      end
      if (mem_req_valid) begin
        assert (!mem_pending) else stop_on_failure("cache issued a second memory request");
        mem_pending = 1'b1;
        if (mem_req.type_ == REQ_WRITE) begin
          mem_writes++;
          write_mask[mem_req.addr[5:2]] = 1'b1;
          assert (mem_reads == 0) else stop_on_failure("writeback word issued after refill");
          assert (mem_req.addr[10:6] == watch_line[4:0])
            else stop_on_failure("writeback went to another index");
          check_equal(cur_test, "writeback data", shadow[mem_req.addr[13:2]], mem_req.data);
        end else begin
          mem_reads++;
          read_mask[mem_req.addr[5:2]] = 1'b1;
          assert (mem_req.addr[31:6] == watch_line)
            else stop_on_failure("refill read outside the requested line");
        end
      end
    end
  end

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("timeout after %0d cycles, the cache stopped answering", MAX_CYCLES);
      $display("Simulation failed");
      $fatal(1);
    end
  end

  initial begin
    reset      <= 1'b1;
    req_valid  <= 1'b0;
    req        <= '0;
    seed        = RAND_SEED;
    exp_opaque  = 8'd0;
    mem_pending = 1'b0;
    mem_reads   = 0;
    mem_writes  = 0;
    read_mask   = '0;
    write_mask  = '0;
    watch_line  = '0;
    for (int i = 0; i < 4096; i++) begin
      shadow[i] = pattern_word(12'(i));
    end
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;

    repeat (IDLE_CYCLES) begin
      @(negedge clk);
      check_equal("reset_state", "busy", 32'd0, 32'(busy));
      check_equal("reset_state", "resp_valid", 32'd0, 32'(resp_valid));
      check_equal("reset_state", "mem_req_valid", 32'd0, 32'(mem_req_valid));
    end

    addr_a = make_addr(21'd1, 5'd5, 4'd3, 2'd0);
    addr_b = make_addr(21'd2, 5'd5, 4'd9, 2'd0);  // same index, other tag

    access("cold_read_miss", REQ_READ, addr_a, 32'd0, lat);
    check_equal("cold_read_miss", "memory reads", 32'd16, 32'(mem_reads));
    check_equal("cold_read_miss", "memory writes", 32'd0, 32'(mem_writes));
    check_equal("cold_read_miss", "refill words", 32'hffff, 32'(read_mask));

    access("read_hit", REQ_READ, addr_a, 32'd0, lat);
    check_equal("read_hit", "latency", 32'd2, 32'(lat));
    check_equal("read_hit", "memory requests", 32'd0, 32'(mem_reads + mem_writes));

    access("write_then_read", REQ_WRITE, addr_a, 32'hcafe_0f17, lat);
    check_equal("write_then_read", "latency", 32'd2, 32'(lat));
    access("write_then_read", REQ_READ, addr_a, 32'd0, lat);
    check_equal("write_then_read", "memory requests", 32'd0, 32'(mem_reads + mem_writes));

    access("dirty_eviction", REQ_READ, addr_b, 32'd0, lat);
    check_equal("dirty_eviction", "memory writes", 32'd16, 32'(mem_writes));
    check_equal("dirty_eviction", "writeback words", 32'hffff, 32'(write_mask));
    check_equal("dirty_eviction", "memory reads", 32'd16, 32'(mem_reads));
    access("dirty_eviction", REQ_READ, addr_a, 32'd0, lat);
    check_equal("dirty_eviction", "reread data", 32'hcafe_0f17, resp.data);

    for (int n = 0; n < RANDOM_OPS; n++) begin
      rnd = $random(seed);
      access("random_mix", rnd[0] ? REQ_WRITE : REQ_READ,
             make_addr(21'(rnd[2:1]), rnd[7:3], rnd[11:8], rnd[13:12]),
             $random(seed), lat);
    end

    $display("Simulation passed");
    $finish;
  end

endmodule

// File: dv/mem_model.sv
module mem_model #(
  parameter int SEED = 1
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 req_valid,
  input  cache_pkg::mem_req_t  req,
  output logic                 resp_valid,
  output cache_pkg::mem_resp_t resp
);
  import cache_pkg::*;

  localparam int WORDS = 4096;

  logic [31:0] mem [WORDS];
  integer      seed;
  integer      delay;
  mem_req_t    held;
  logic        pending;
  logic [1:0]  wait_left;
  logic        fire;
  logic [11:0] widx;

  // every word differs, built from the full word address
  function automatic logic [31:0] fill_word(input logic [11:0] a);
    return {a, 4'h5, a, 4'ha} ^ 32'h3c00_00c3;
  endfunction

  initial begin
    seed = SEED;
    for (int i = 0; i < WORDS; i++) begin
      mem[i] = fill_word(12'(i));
    end
    resp_valid <= 1'b0;
    resp       <= '0;
    pending    <= 1'b0;
    wait_left  <= '0;
  end

  always @(posedge clk) begin
    if (reset) begin
      pending    <= 1'b0;
      resp_valid <= 1'b0;
    end else begin
      fire = 1'b0;
      resp_valid <= 1'b0;
      if (req_valid) begin
        held  = req;
        delay = 1 + ($random(seed) & 3);  // 1 to 4 cycles
        if (delay == 1) begin
          fire = 1'b1;
        end else begin
          pending   <= 1'b1;
          wait_left <= 2'(delay - 1);
        end
      end else if (pending) begin
        if (wait_left == 2'd1) begin
          fire = 1'b1;
          pending <= 1'b0;
        end else begin
          wait_left <= wait_left - 2'd1;
        end
      end
      if (fire) begin
        widx = held.addr[13:2];
        resp_valid <= 1'b1;
        if (held.type_ == REQ_WRITE) begin
          mem[widx] = held.data;
          resp.data <= '0;
        end else begin
          resp.data <= mem[widx];
        end
      end
    end
  end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert -Wno-fatal --top-module cache_tb \
  -f cache.f --Mdir obj_dir -o cache_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/cache_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Simulation failed" "$LOG"; then
  echo "FAIL"
  exit 1
fi
if [ $status -ne 0 ]; then
  echo "simulator exited with status $status"
  exit 1
fi
echo "PASS"
exit 0

// File: source/cache_ctrl.sv
`include "cache_cfg.svh"

module cache_ctrl (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         req_valid,
  input  cache_pkg::cache_req_t        cur_req,
  input  logic [`CACHE_TAG_BITS-1:0]   cur_tag,
  input  logic [`CACHE_INDEX_BITS-1:0] cur_index,
  input  logic                         hit,
  input  logic                         victim_dirty,
  input  logic [`CACHE_TAG_BITS-1:0]   victim_tag,
  output logic                         busy,
  output logic                         line_word_we,
  output logic                         fill_sel,
  output logic [`CACHE_WOFS_BITS-1:0]  word_count,
  output logic                         tag_we,
  output logic                         mem_req_valid,
  output cache_pkg::mem_req_t          mem_req,
  input  logic                         mem_resp_valid,
  output logic                         hit_done
);
  import cache_pkg::*;

  typedef enum logic [2:0] {IDLE, LOOKUP, WRITEBACK, REFILL, RESPOND} state_e;

  state_e      state;
  state_e      state_next;
  logic        mem_wait;
  logic        mem_done;
  logic        last_word;
  cache_addr_u mem_addr;

  assign mem_done  = mem_wait && mem_resp_valid;
  assign last_word = &word_count;  // all ones on word 15
  assign busy      = (state != IDLE);

  always_comb begin
    state_next   = state;
    line_word_we = 1'b0;
    fill_sel     = 1'b0;
    tag_we       = 1'b0;
    hit_done     = 1'b0;
    case (state)
      IDLE: begin
        if (req_valid) state_next = LOOKUP;
      end
      LOOKUP: begin
        if (hit) begin
          hit_done     = 1'b1;
          line_word_we = (cur_req.type_ == REQ_WRITE);  // write hit stores client word
          state_next   = RESPOND;
        end else if (victim_dirty) begin
          state_next = WRITEBACK;
        end else begin
          state_next = REFILL;
        end
      end
      WRITEBACK: begin
        if (mem_done && last_word) state_next = REFILL;
      end
      REFILL: begin
        fill_sel = 1'b1;
        if (mem_done) begin
          line_word_we = 1'b1;
          if (last_word) begin
            tag_we     = 1'b1;
            state_next = LOOKUP;  // replay as a hit
          end
        end
      end
      RESPOND: state_next = IDLE;
      default: state_next = IDLE;
    endcase
  end

  // one outstanding memory request at a time
  assign mem_req_valid = (state == WRITEBACK || state == REFILL) && !mem_wait;

  always_comb begin
    mem_addr.f.tag   = (state == WRITEBACK) ? victim_tag : cur_tag;
    mem_addr.f.index = cur_index;
    mem_addr.f.wofs  = word_count;
    mem_addr.f.bofs  = '0;
  end

  assign mem_req.type_ = (state == WRITEBACK) ? REQ_WRITE : REQ_READ;
  assign mem_req.addr  = mem_addr.raw;
  assign mem_req.data  = '0;  // victim data merged at top

  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= IDLE;
      mem_wait   <= 1'b0;
      word_count <= '0;
    end else begin
      state <= state_next;
      if (mem_req_valid) begin
        mem_wait <= 1'b1;
      end else if (mem_resp_valid) begin
        mem_wait <= 1'b0;
      end
      // wraps back to 0 after each 16-word burst
      if (mem_done) word_count <= word_count + 1'b1;
    end
  end

endmodule

// File: source/cache_decode.sv
`include "cache_cfg.svh"

module cache_decode (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         req_valid,
  input  cache_pkg::cache_req_t        req,
  output cache_pkg::cache_req_t        cur_req,
  output logic [`CACHE_TAG_BITS-1:0]   cur_tag,
  output logic [`CACHE_INDEX_BITS-1:0] cur_index,
  output logic [`CACHE_WOFS_BITS-1:0]  cur_wofs
);
  import cache_pkg::*;

  cache_addr_u addr_view;

  // request held for the whole transaction
  always_ff @(posedge clk) begin
    if (reset) begin
      cur_req <= '0;
    end else if (req_valid) begin
      cur_req <= req;
    end
  end

  assign addr_view.raw = cur_req.addr.raw;

  assign cur_tag   = addr_view.f.tag;
  assign cur_index = addr_view.f.index;
  assign cur_wofs  = addr_view.f.wofs;  // byte offset dropped

endmodule

// File: source/cache_execute.sv
`include "cache_cfg.svh"

module cache_execute (
  input  logic                            clk,
  input  logic                            reset,
  input  logic [`CACHE_INDEX_BITS-1:0]    cur_index,
  input  logic [`CACHE_TAG_BITS-1:0]      cur_tag,
  input  logic [`CACHE_WOFS_BITS-1:0]     cur_wofs,
  input  logic [`CACHE_WOFS_BITS-1:0]     word_count,
  input  logic                            fill_sel,
  input  logic                            line_word_we,
  input  logic                            tag_we,
  input  logic [31:0]                     client_data,
  input  logic [31:0]                     mem_data,
  input  logic                            set_dirty,
  output logic                            hit,
  output logic                            victim_dirty,
  output logic [`CACHE_TAG_BITS-1:0]      victim_tag,
  output logic [`CACHE_LINE_WORDS*32-1:0] line_data
);

  logic [`CACHE_TAG_BITS-1:0]  tag_mem  [`CACHE_LINES];
  logic [31:0]                 data_mem [`CACHE_LINES][`CACHE_LINE_WORDS];
  logic [`CACHE_LINES-1:0]     valid_bits;
  logic [`CACHE_LINES-1:0]     dirty_bits;
  logic [`CACHE_WOFS_BITS-1:0] word_sel;
  logic [`CACHE_LINE_WORDS-1:0] word_we;
  logic [31:0]                 word_wdata;

  assign word_sel   = fill_sel ? word_count : cur_wofs;
  assign word_wdata = fill_sel ? mem_data : client_data;
  assign word_we    = line_word_we ? (`CACHE_LINE_WORDS'(1) << word_sel) : '0;

  always_ff @(posedge clk) begin
    for (int w = 0; w < `CACHE_LINE_WORDS; w++) begin
      if (word_we[w]) data_mem[cur_index][w] <= word_wdata;
    end
  end

  always_ff @(posedge clk) begin
    if (tag_we) tag_mem[cur_index] <= cur_tag;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_bits <= '0;
      dirty_bits <= '0;
    end else if (tag_we) begin
      valid_bits[cur_index] <= 1'b1;  // fresh line is clean
      dirty_bits[cur_index] <= 1'b0;
    end else if (line_word_we && !fill_sel && set_dirty) begin
      dirty_bits[cur_index] <= 1'b1;
    end
  end

  assign victim_tag   = tag_mem[cur_index];
  assign victim_dirty = valid_bits[cur_index] && dirty_bits[cur_index];
  assign hit          = valid_bits[cur_index] && (victim_tag == cur_tag);

  for (genvar w = 0; w < `CACHE_LINE_WORDS; w++) begin : g_line
    assign line_data[w*32 +: 32] = data_mem[cur_index][w];
  end

endmodule

// File: source/cache_pkg.sv
`include "cache_cfg.svh"

package cache_pkg;

  typedef enum logic {
    REQ_READ  = 1'b0,
    REQ_WRITE = 1'b1
  } req_type_e;

  typedef struct packed {
    logic [`CACHE_TAG_BITS-1:0]   tag;
    logic [`CACHE_INDEX_BITS-1:0] index;
    logic [`CACHE_WOFS_BITS-1:0]  wofs;
    logic [`CACHE_BOFS_BITS-1:0]  bofs;
  } cache_addr_t;

  // one address word, seen raw or as its fields
  typedef union packed {
    logic [31:0] raw;
    cache_addr_t f;
  } cache_addr_u;

  typedef struct packed {
    req_type_e   type_;
    logic [7:0]  opaque;
    cache_addr_u addr;
    logic [31:0] data;
  } cache_req_t;

  typedef struct packed {
    req_type_e   type_;
    logic [7:0]  opaque;
    logic [31:0] data;  // undefined for writes
  } cache_resp_t;

  typedef struct packed {
    req_type_e   type_;
    logic [31:0] addr;
    logic [31:0] data;
  } mem_req_t;

  typedef struct packed {
    logic [31:0] data;  // zero-ignored on write acks
  } mem_resp_t;

endpackage

// File: source/cache_result.sv
`include "cache_cfg.svh"

module cache_result (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            hit_done,
  input  cache_pkg::cache_req_t           cur_req,
  input  logic [`CACHE_WOFS_BITS-1:0]     cur_wofs,
  input  logic [`CACHE_LINE_WORDS*32-1:0] line_data,
  input  logic [`CACHE_WOFS_BITS-1:0]     word_count,
  output logic                            resp_valid,
  output cache_pkg::cache_resp_t          resp,
  output logic [31:0]                     wb_data
);

  logic [31:0] resp_word;

  function automatic logic [31:0] line_word(
    input logic [`CACHE_LINE_WORDS*32-1:0] line,
    input logic [`CACHE_WOFS_BITS-1:0]     sel
  );
    return line[sel*32 +: 32];
  endfunction

  assign resp_word = line_word(line_data, cur_wofs);
  assign wb_data   = line_word(line_data, word_count);  // victim word for writeback

  always_ff @(posedge clk) begin
    if (reset) begin
      resp_valid <= 1'b0;
    end else begin
      resp_valid <= hit_done;
    end
  end

  always_ff @(posedge clk) begin
    if (hit_done) begin
      resp.type_  <= cur_req.type_;
      resp.opaque <= cur_req.opaque;
      resp.data   <= resp_word;
    end
  end

endmodule

// File: source/cache_top.sv
`include "cache_cfg.svh"

module cache_top (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   req_valid,
  input  cache_pkg::cache_req_t  req,
  output logic                   busy,
  output logic                   resp_valid,
  output cache_pkg::cache_resp_t resp,
  output logic                   mem_req_valid,
  output cache_pkg::mem_req_t    mem_req,
  input  logic                   mem_resp_valid,
  input  cache_pkg::mem_resp_t   mem_resp
);
  import cache_pkg::*;

  cache_req_t                      cur_req;
  logic [`CACHE_TAG_BITS-1:0]      cur_tag;
  logic [`CACHE_INDEX_BITS-1:0]    cur_index;
  logic [`CACHE_WOFS_BITS-1:0]     cur_wofs;
  logic                            hit;
  logic                            victim_dirty;
  logic [`CACHE_TAG_BITS-1:0]      victim_tag;
  logic                            line_word_we;
  logic                            fill_sel;
  logic [`CACHE_WOFS_BITS-1:0]     word_count;
  logic                            tag_we;
  logic                            hit_done;
  logic [`CACHE_LINE_WORDS*32-1:0] line_data;
  logic [31:0]                     wb_data;
  mem_req_t                        ctrl_mem_req;

  cache_decode u_decode (
    .clk       (clk),
    .reset     (reset),
    .req_valid (req_valid),
    .req       (req),
    .cur_req   (cur_req),
    .cur_tag   (cur_tag),
    .cur_index (cur_index),
    .cur_wofs  (cur_wofs)
  );

  cache_ctrl u_ctrl (
    .clk            (clk),
    .reset          (reset),
    .req_valid      (req_valid),
    .cur_req        (cur_req),
    .cur_tag        (cur_tag),
    .cur_index      (cur_index),
    .hit            (hit),
    .victim_dirty   (victim_dirty),
    .victim_tag     (victim_tag),
    .busy           (busy),
    .line_word_we   (line_word_we),
    .fill_sel       (fill_sel),
    .word_count     (word_count),
    .tag_we         (tag_we),
    .mem_req_valid  (mem_req_valid),
    .mem_req        (ctrl_mem_req),
    .mem_resp_valid (mem_resp_valid),
    .hit_done       (hit_done)
  );

  // dirty only on a client write
  cache_execute u_execute (
    .clk          (clk),
    .reset        (reset),
    .cur_index    (cur_index),
    .cur_tag      (cur_tag),
    .cur_wofs     (cur_wofs),
    .word_count   (word_count),
    .fill_sel     (fill_sel),
    .line_word_we (line_word_we),
    .tag_we       (tag_we),
    .client_data  (cur_req.data),
    .mem_data     (mem_resp.data),
    .set_dirty    (cur_req.type_),
    .hit          (hit),
    .victim_dirty (victim_dirty),
    .victim_tag   (victim_tag),
    .line_data    (line_data)
  );

  cache_result u_result (
    .clk        (clk),
    .reset      (reset),
    .hit_done   (hit_done),
    .cur_req    (cur_req),
    .cur_wofs   (cur_wofs),
    .line_data  (line_data),
    .word_count (word_count),
    .resp_valid (resp_valid),
    .resp       (resp),
    .wb_data    (wb_data)
  );

  assign mem_req.type_ = ctrl_mem_req.type_;
  assign mem_req.addr  = ctrl_mem_req.addr;
  assign mem_req.data  = wb_data;  // victim line word at word_count

endmodule
